/* hdl/calc_pkg.sv */
package calc_pkg;

    // Operand and result width, results wrap modulo 2^OPERAND_W
    localparam int OPERAND_W = 16;

    // Keypad code width
    localparam int KEY_W = 4;

    // One-hot operator code
    typedef logic [2:0] op_t;

    localparam op_t OP_ADD = 3'b001;
    localparam op_t OP_SUB = 3'b010;
    localparam op_t OP_MUL = 3'b100;

    // Key codes 1..9 are the digits themselves
    localparam logic [KEY_W-1:0] KEY_NONE = 4'd0;
    localparam logic [KEY_W-1:0] KEY_ZERO = 4'd10;  // Highest valid code

    // One queued calculation, 35 bits
    typedef struct packed {
        op_t                  op;
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } calc_job_t;

endpackage

/* hdl/wb_pkg.sv */
package wb_pkg;

    // Wishbone classic cycle control, driven by the master.
    // Data and ack are kept beside it since their types differ per port.
    typedef struct packed {
        logic cyc;  // Bus cycle in progress
        logic stb;  // Valid transfer request
        logic we;   // Write when high, read when low
    } wb_ctl_t;

    // No cycle on the bus
    localparam wb_ctl_t WB_IDLE = '{cyc: 1'b0, stb: 1'b0, we: 1'b0};

endpackage

/* hdl/digit_entry.sv */
`timescale 1ns/1ps

module digit_entry (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::KEY_W-1:0]  keypad_input,
    input  calc_pkg::op_t               operator_input,
    input  logic                        equal_input,
    input  logic                        wr_ack,
    output wb_pkg::wb_ctl_t             wr_ctl,
    output calc_pkg::calc_job_t         wr_data
);
    import calc_pkg::*;
    import wb_pkg::*;

    typedef enum logic [1:0] {
        PH_FIRST,     // Entering operand a
        PH_SECOND,    // Entering operand b
        PH_WAIT_ACK   // Job offered to the queue
    } phase_t;

    phase_t               phase;
    logic [KEY_W-1:0]     prev_key;
    logic [OPERAND_W-1:0] opnd_a;
    logic [OPERAND_W-1:0] opnd_b;
    op_t                  op_q;
    logic                 key_press;
    logic                 op_valid;
    logic [OPERAND_W-1:0] digit;

    // Decimal shift in: 10*x + d, done as 8x + 2x + d
    function automatic logic [OPERAND_W-1:0] push_digit(
        input logic [OPERAND_W-1:0] x,
        input logic [OPERAND_W-1:0] d
    );
        return (x << 3) + (x << 1) + d;
    endfunction

    // Rising edge from no key to a valid digit code
    assign key_press = (prev_key == KEY_NONE) && (keypad_input != KEY_NONE)
                       && (keypad_input <= KEY_ZERO);
    assign digit     = (keypad_input == KEY_ZERO) ? '0 : OPERAND_W'(keypad_input);
    assign op_valid  = $onehot(operator_input);  // Exactly one operator bit

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            phase    <= PH_FIRST;
            prev_key <= KEY_NONE;
            opnd_a   <= '0;
            opnd_b   <= '0;
            op_q     <= OP_ADD;
        end else begin
            prev_key <= keypad_input;
            case (phase)
                PH_FIRST: begin
                    if (key_press)
                        opnd_a <= push_digit(opnd_a, digit);
                    if (op_valid) begin
                        op_q  <= operator_input;
                        phase <= PH_SECOND;
                    end
                end
                PH_SECOND: begin
                    if (key_press)
                        opnd_b <= push_digit(opnd_b, digit);
                    if (equal_input)
                        phase <= PH_WAIT_ACK;
                end
                PH_WAIT_ACK: begin
                    if (wr_ack) begin  // Job taken, start over
                        phase  <= PH_FIRST;
                        opnd_a <= '0;
                        opnd_b <= '0;
                    end
                end
                default: phase <= PH_FIRST;
            endcase
        end
    end

    always_comb begin
        wr_ctl    = WB_IDLE;
        wr_ctl.we = 1'b1;  // Write-only master
        if (phase == PH_WAIT_ACK) begin
            wr_ctl.cyc = 1'b1;
            wr_ctl.stb = 1'b1;
        end
    end

    assign wr_data = '{op: op_q, a: opnd_a, b: opnd_b};

endmodule

/* hdl/job_queue.sv */
`timescale 1ns/1ps

module job_queue #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic            clk,
    input  logic            nRST,
    input  wb_pkg::wb_ctl_t wr_ctl,
    input  payload_t        wr_data,
    output logic            wr_ack,
    input  wb_pkg::wb_ctl_t rd_ctl,
    output payload_t        rd_data,
    output logic            rd_ack
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Classic slave ack, raised in the same cycle as the strobe
    assign wr_ack = wr_ctl.cyc && wr_ctl.stb && wr_ctl.we && !full;
    assign rd_ack = rd_ctl.cyc && rd_ctl.stb && !rd_ctl.we && !empty;

    // Transfers complete at the edge where ack is high
    assign push = wr_ack;
    assign pop  = rd_ack;

    assign rd_data = mem[rd_ptr];  // Head entry, valid with rd_ack

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

endmodule

/* hdl/add_sub_unit.sv */
`timescale 1ns/1ps

module add_sub_unit (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          start,
    input  logic                          sub,
    input  logic [calc_pkg::OPERAND_W-1:0] a,
    input  logic [calc_pkg::OPERAND_W-1:0] b,
    output logic [calc_pkg::OPERAND_W-1:0] result,
    output logic                          finish
);

    // Result wraps naturally at the operand width
    always_ff @(posedge clk) begin
        if (start) begin
            if (sub)
                result <= a - b;
            else
                result <= a + b;
        end
    end

    // One-cycle finish, one edge after start
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            finish <= 1'b0;
        else
            finish <= start;
    end

endmodule

/* hdl/shift_add_mult.sv */
`timescale 1ns/1ps

module shift_add_mult (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          start,
    input  logic [calc_pkg::OPERAND_W-1:0] a,
    input  logic [calc_pkg::OPERAND_W-1:0] b,
    output logic [calc_pkg::OPERAND_W-1:0] result,
    output logic                          finish
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(OPERAND_W);

    logic [OPERAND_W-1:0] mcand;   // Shifts left each step
    logic [OPERAND_W-1:0] mplier;  // Shifts right each step
    logic [OPERAND_W-1:0] acc;
    logic [CNT_W-1:0]     count;   // Multiplier bits consumed
    logic                 busy;

    // Datapath, bit 0 of b is folded into the start edge
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
        end else if (busy) begin
            if (mplier[0])
                acc <= acc + mcand;  // Low bits only, product wraps
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(OPERAND_W - 1)) begin  // Last bit added
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    assign result = acc;

endmodule

/* hdl/calc_engine.sv */
`timescale 1ns/1ps

module calc_engine (
    input  logic                          clk,
    input  logic                          nRST,
    input  calc_pkg::calc_job_t           rd_data,
    input  logic                          rd_ack,
    output wb_pkg::wb_ctl_t               rd_ctl,
    input  logic [calc_pkg::OPERAND_W-1:0] as_result,
    input  logic                          as_finish,
    input  logic [calc_pkg::OPERAND_W-1:0] mul_result,
    input  logic                          mul_finish,
    output logic                          as_start,
    output logic                          as_sub,
    output logic                          mul_start,
    output logic [calc_pkg::OPERAND_W-1:0] a,
    output logic [calc_pkg::OPERAND_W-1:0] b,
    output logic                          complete,
    output logic [calc_pkg::OPERAND_W-1:0] display_output
);
    import calc_pkg::*;
    import wb_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,     // Reading a job from the queue
        ST_DISPATCH,  // Start pulse to one unit
        ST_WAIT,      // Unit busy
        ST_SHOW       // Complete pulse high
    } state_t;

    state_t               state;
    calc_job_t            job;
    logic                 is_mul;
    logic                 unit_finish;
    logic [OPERAND_W-1:0] unit_result;

    assign is_mul      = (job.op == OP_MUL);
    assign unit_finish = is_mul ? mul_finish : as_finish;
    assign unit_result = is_mul ? mul_result : as_result;

    // Job latched at the read edge
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && rd_ack)
            job <= rd_data;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ST_FETCH;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= 1'b0;
            case (state)
                ST_FETCH: begin
                    if (rd_ack)
                        state <= ST_DISPATCH;
                end
                ST_DISPATCH: state <= ST_WAIT;
                ST_WAIT: begin
                    if (unit_finish) begin
                        display_output <= unit_result;  // Held until next job
                        complete       <= 1'b1;
                        state          <= ST_SHOW;
                    end
                end
                ST_SHOW: state <= ST_FETCH;
                default: state <= ST_FETCH;
            endcase
        end
    end

    // Read master: strobe only while fetching, dropped after ack
    always_comb begin
        rd_ctl = WB_IDLE;
        if (state == ST_FETCH) begin
            rd_ctl.cyc = 1'b1;
            rd_ctl.stb = 1'b1;
        end
    end

    assign as_start  = (state == ST_DISPATCH) && !is_mul;
    assign mul_start = (state == ST_DISPATCH) && is_mul;
    assign as_sub    = (job.op == OP_SUB);
    assign a         = job.a;
    assign b         = job.b;

endmodule

/* hdl/calc_top.sv */
`timescale 1ns/1ps

module calc_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::KEY_W-1:0]     keypad_input,
    input  calc_pkg::op_t                 operator_input,
    input  logic                          equal_input,
    output logic                          complete,
    output logic [calc_pkg::OPERAND_W-1:0] display_output
);
    import calc_pkg::*;
    import wb_pkg::*;

    // Producer side of the queue
    wb_ctl_t              wr_ctl;
    calc_job_t            wr_data;
    logic                 wr_ack;

    // Consumer side of the queue
    wb_ctl_t              rd_ctl;
    calc_job_t            rd_data;
    logic                 rd_ack;

    // Engine to arithmetic units
    logic                 as_start;
    logic                 as_sub;
    logic                 as_finish;
    logic                 mul_start;
    logic                 mul_finish;
    logic [OPERAND_W-1:0] opnd_a;
    logic [OPERAND_W-1:0] opnd_b;
    logic [OPERAND_W-1:0] as_result;
    logic [OPERAND_W-1:0] mul_result;

    digit_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .wr_ack         (wr_ack),
        .wr_ctl         (wr_ctl),
        .wr_data        (wr_data)
    );

    job_queue #(
        .DEPTH     (QUEUE_DEPTH),
        .payload_t (calc_job_t)
    ) u_queue (
        .clk     (clk),
        .nRST    (nRST),
        .wr_ctl  (wr_ctl),
        .wr_data (wr_data),
        .wr_ack  (wr_ack),
        .rd_ctl  (rd_ctl),
        .rd_data (rd_data),
        .rd_ack  (rd_ack)
    );

    calc_engine u_engine (
        .clk            (clk),
        .nRST           (nRST),
        .rd_data        (rd_data),
        .rd_ack         (rd_ack),
        .rd_ctl         (rd_ctl),
        .as_result      (as_result),
        .as_finish      (as_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .as_start       (as_start),
        .as_sub         (as_sub),
        .mul_start      (mul_start),
        .a              (opnd_a),
        .b              (opnd_b),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (as_start),
        .sub    (as_sub),
        .a      (opnd_a),
        .b      (opnd_b),
        .result (as_result),
        .finish (as_finish)
    );

    shift_add_mult u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mul_start),
        .a      (opnd_a),
        .b      (opnd_b),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

/* verif/calc_checker.sv */
`timescale 1ns/1ps

module calc_checker (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           complete,
    input  logic [calc_pkg::OPERAND_W-1:0] display_output,
    input  logic                           exp_valid,
    input  logic [calc_pkg::OPERAND_W-1:0] exp_value,
    input  logic                           end_check,
    output int                             errors,
    output int                             pending,
    output int                             checked
);
    import calc_pkg::*;

    logic [OPERAND_W-1:0] expected_q[$];  // Oldest expectation at the front
    int                   pushed;
    logic                 end_done;

    initial begin
        errors   = 0;
        pending  = 0;
        checked  = 0;
        pushed   = 0;
        end_done = 1'b0;
    end

    // DUT outputs are registered, so the pre-edge values are the settled ones
    always @(posedge clk) begin : compare
        logic [OPERAND_W-1:0] want;
        if (nRST) begin
            if (pushed == 0 && display_output !== '0) begin  // Nothing computed yet
                $display("error: display_output expected %h, got %h", 16'h0000, display_output);
                errors = errors + 1;
            end
            if (exp_valid) begin
                expected_q.push_back(exp_value);
                pushed = pushed + 1;
            end
            if (complete) begin
                if (expected_q.size() == 0) begin
                    $display("A result completed with no calculation waiting for it");
                    errors = errors + 1;
                end else begin
                    want    = expected_q.pop_front();
                    checked = checked + 1;
                    if (display_output !== want) begin
                        $display("error: display_output expected %h, got %h",
                                 want, display_output);
                        errors = errors + 1;
                    end
                end
            end
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (expected_q.size() != 0) begin
                    $display("%0d calculations never produced a result", expected_q.size());
                    errors = errors + 1;
                end
            end
            pending = expected_q.size();
        end
    end

endmodule

/* verif/calc_tb.sv */
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    localparam int N_ADD   = 4;
    localparam int ADD_DIG = 10;
    localparam int N_SUB   = 3;
    localparam int SUB_DIG = 5;
    localparam int N_MUL   = 3;
    localparam int MUL_DIG = 5;
    localparam int MIX_DIG = 10;  // Held and ignored keys included
    localparam int N_BURST = 10;
    localparam int BUR_DIG = 2;
    localparam int N_JOBS  = N_ADD + N_SUB + N_MUL + 1 + N_BURST;
    localparam int LIMIT   = 20 + N_ADD * (ADD_DIG * 3 + 40) + N_SUB * (SUB_DIG * 3 + 40)
                             + N_MUL * (MUL_DIG * 3 + 40) + (MIX_DIG * 3 + 40)
                             + N_BURST * (BUR_DIG * 3 + 40);
    localparam longint MOD = longint'(1) << OPERAND_W;

    logic                 clk;
    logic                 nRST;
    logic [KEY_W-1:0]     keypad_input;
    op_t                  operator_input;
    logic                 equal_input;
    logic                 complete;
    logic [OPERAND_W-1:0] display_output;
    logic                 exp_valid;
    logic [OPERAND_W-1:0] exp_value;
    logic                 end_check;
    int                   errors;
    int                   pending;
    int                   checked;
    int                   cycles;
    int                   seed;

    calc_top dut0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_checker chk0 (
        .clk            (clk),
        .nRST           (nRST),
        .complete       (complete),
        .display_output (display_output),
        .exp_valid      (exp_valid),
        .exp_value      (exp_value),
        .end_check      (end_check),
        .errors         (errors),
        .pending        (pending),
        .checked        (checked)
    );

    always #50 clk = ~clk;

    // Expected display value, every result taken modulo 2^16
    function automatic logic [OPERAND_W-1:0] expected_result(
        input op_t                  op,
        input logic [OPERAND_W-1:0] a,
        input logic [OPERAND_W-1:0] b
    );
        longint wide;
        case (op)
            OP_ADD:  wide = longint'(a) + longint'(b);
            OP_SUB:  wide = longint'(a) + MOD - longint'(b);  // Wraps below zero
            default: wide = longint'(a) * longint'(b);
        endcase
        return OPERAND_W'(wide % MOD);
    endfunction

    function automatic int digit_value(input logic [KEY_W-1:0] code);
        return (code == KEY_ZERO) ? 0 : int'(code);
    endfunction

    // All stimulus tasks start and end on a falling edge
    task automatic press_key(input logic [KEY_W-1:0] code, input int hold);
        keypad_input = code;
        repeat (hold) @(negedge clk);
        keypad_input = KEY_NONE;
        @(negedge clk);
    endtask

    task automatic pulse_operator(input op_t op);
        operator_input = op;
        @(negedge clk);
        operator_input = '0;
    endtask

    task automatic enter_digits(input int ndig, input bit lead_nonzero, input bit with_zero,
                                output logic [OPERAND_W-1:0] value);
        logic [KEY_W-1:0] code;
        value = '0;
        for (int i = 0; i < ndig; i++) begin
            if (i == 0 && lead_nonzero)
                code = KEY_W'($urandom_range(1, 9));
            else if (i == 1 && with_zero)
                code = KEY_ZERO;
            else
                code = KEY_W'($urandom_range(1, 10));
            press_key(code, 2);
            value = value * 10 + digit_value(code);  // Wraps at 16 bits
        end
    endtask

    // Equal and the expectation go out together, then wait for the queue
    task automatic finish_job(input op_t op, input logic [OPERAND_W-1:0] a,
                              input logic [OPERAND_W-1:0] b);
        equal_input = 1'b1;
        exp_valid   = 1'b1;
        exp_value   = expected_result(op, a, b);
        @(negedge clk);
        equal_input = 1'b0;
        exp_valid   = 1'b0;
        while (!dut0.wr_ack)
            @(negedge clk);
        @(negedge clk);  // Job taken at this rising edge
    endtask

    task automatic run_job(input op_t op, input int na, input int nb,
                           input bit b_large, input bit with_zero);
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        enter_digits(na, 1'b0, with_zero, a);
        pulse_operator(op);
        enter_digits(nb, b_large, 1'b0, b);
        finish_job(op, a, b);
    endtask

    // Held key, codes 11..15 and a non one-hot operator all leave the operands alone
    task automatic run_mixed_job();
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
        logic [KEY_W-1:0]     code;
        code = KEY_W'($urandom_range(1, 9));
        press_key(code, 6);
        a    = OPERAND_W'(digit_value(code));
        press_key(KEY_W'(11 + $urandom_range(0, 4)), 2);
        code = KEY_W'($urandom_range(1, 10));
        press_key(code, 2);
        a    = a * 10 + digit_value(code);
        pulse_operator(3'b011);
        pulse_operator(OP_SUB);
        code = KEY_W'($urandom_range(1, 10));
        press_key(code, 2);
        b    = OPERAND_W'(digit_value(code));
        press_key(4'd15, 3);
        code = KEY_W'($urandom_range(1, 10));
        press_key(code, 4);
        b    = b * 10 + digit_value(code);
        finish_job(OP_SUB, a, b);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT did not finish all jobs", LIMIT);
            $display("errors: %0d, results checked: %0d of %0d", errors, checked, N_JOBS);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed           = 78142;
        void'($urandom(seed));
        cycles         = 0;
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = KEY_NONE;
        operator_input = '0;
        equal_input    = 1'b0;
        exp_valid      = 1'b0;
        exp_value      = '0;
        end_check      = 1'b0;
        repeat (4) @(negedge clk);
        nRST = 1'b1;
        repeat (5) @(negedge clk);  // Idle display must read zero
        for (int i = 0; i < N_ADD; i++)
            run_job(OP_ADD, 5, 5, 1'b0, 1'b0);  // Operands and sums can wrap
        for (int i = 0; i < N_SUB; i++)
            run_job(OP_SUB, 1, 4, 1'b1, 1'b0);  // Smaller first operand
        for (int i = 0; i < N_MUL; i++)
            run_job(OP_MUL, 3, 2, 1'b0, 1'b1);
        run_mixed_job();
        for (int i = 0; i < N_BURST; i++)
            run_job(OP_MUL, 1, 1, 1'b0, 1'b0);  // Fills the queue behind the multiplier
        while (pending != 0 && cycles < LIMIT - 10)  // Drain, ending short of the run limit
            @(negedge clk);
        repeat (5) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        $display("errors: %0d, results checked: %0d of %0d", errors, checked, N_JOBS);
        if (errors == 0 && checked == N_JOBS)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* sim.f */
hdl/calc_pkg.sv
hdl/wb_pkg.sv
hdl/digit_entry.sv
hdl/job_queue.sv
hdl/add_sub_unit.sv
hdl/shift_add_mult.sv
hdl/calc_engine.sv
hdl/calc_top.sv
verif/calc_checker.sv
verif/calc_tb.sv
